// ==== verilog/cam_pkg.sv ====
/*
  Camera sensor package
  Raw sample width, line buffer depth and the counter types
  used by the capture and demosaic stages
*/
`default_nettype none

package cam_pkg;

  //======================================================================
  // Sensor sample
  //======================================================================
  localparam int unsigned raw_width = 12;   // DM5 sensor ADC bits

  typedef logic [raw_width-1:0] raw_pixel_t;

  //======================================================================
  // Frame geometry
  //======================================================================
  localparam int unsigned line_width_max = 640;  // VGA line
  localparam int unsigned line_addr_width = $clog2(line_width_max);

  // Column or row index
  typedef logic [15:0] coord_t;

  // Accepted frames since reset
  typedef logic [31:0] frame_count_t;

endpackage

`default_nettype wire

// ==== verilog/pix_pkg.sv ====
/*
  Pixel output package
  Colour component types, the packed 16-bit output word
  and the seven-segment display constants
*/
`default_nettype none

package pix_pkg;

  //======================================================================
  // Colour components
  //======================================================================
  localparam int unsigned comp_width = 12;  // Full precision per channel
  localparam int unsigned comp5_width = 5;  // Kept MSBs per channel
  localparam int unsigned word_width = 16;  // Bus word to memory side

  typedef logic [comp_width-1:0] comp_t;
  typedef logic [comp5_width-1:0] comp5_t;

  // Pad bit on top, blue in the low bits
  typedef struct packed {
    logic   pad;    // Always zero
    comp5_t red;
    comp5_t green;
    comp5_t blue;
  } rgb555_t;

  // Same word seen as bus data or as colour fields
  typedef union packed {
    logic [word_width-1:0] raw;
    rgb555_t               fields;
  } pixel_word_u;

  //======================================================================
  // Frame counter display
  //======================================================================
  localparam int unsigned hex_digits = 6;   // HEX0 to HEX5
  localparam int unsigned seg_width = 7;

  // Active low, bit 6 is segment g
  typedef logic [seg_width-1:0] seg_t;

endpackage

`default_nettype wire

// ==== verilog/ccd_stream_if.sv ====
/*
  Captured pixel stream
  Raw sample with its valid and position, from capture to demosaic
*/
`default_nettype none

interface ccd_stream_if;
  import cam_pkg::*;

  raw_pixel_t data;   // Sensor sample
  logic       dval;   // Sample belongs to an accepted frame
  coord_t     x;      // Column of data
  coord_t     y;      // Row of data

  modport source (
    output data, dval, x, y
  );

  modport sink (
    input data, dval, x, y
  );

endinterface

`default_nettype wire

// ==== verilog/ccd_capture.sv ====
/*
  CCD capture
  Registers the sensor pins, runs and stops acquisition from the
  start and stop keys, counts accepted frames and tags every valid
  sample with its column and row. Two cycles from pin sample to dval
*/
`default_nettype none

module ccd_capture (
  input  logic                  ccd_pixel_clk,
  input  logic                  hps_fpga_reset_n,
  input  cam_pkg::raw_pixel_t   ccd_data,
  input  logic                  ccd_fval,
  input  logic                  ccd_lval,
  input  logic                  start_n,
  input  logic                  stop_n,
  ccd_stream_if.source          stream,
  output cam_pkg::frame_count_t frame_count
);
  import cam_pkg::*;

  raw_pixel_t data_pin;             // Pin stage
  raw_pixel_t data_dly;             // Edge detect stage
  logic       fval_pin, lval_pin;
  logic       fval_dly, lval_dly;
  logic       lval_out;             // Line valid aligned with stream
  logic       running;              // Set by start key
  logic       accepted;             // Current frame is being captured
  logic       fval_rise, fval_fall;
  logic       lval_fall;
  logic       frame_start;

  // Edges seen between pin stage and delay stage
  assign fval_rise = fval_pin & ~fval_dly;
  assign fval_fall = ~fval_pin & fval_dly;
  // Line end seen on the stream side so x holds until the last sample
  assign lval_fall = lval_out & ~lval_dly;
  // Stop key has priority over a new frame
  assign frame_start = fval_rise & running & stop_n;

  //======================================================================
  // Data path, no reset
  //======================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    data_pin    <= ccd_data;
    data_dly    <= data_pin;
    stream.data <= data_dly;
  end

  //======================================================================
  // Control
  //======================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      fval_pin    <= 1'b0;
      lval_pin    <= 1'b0;
      fval_dly    <= 1'b0;
      lval_dly    <= 1'b0;
      lval_out    <= 1'b0;
      running     <= 1'b0;
      accepted    <= 1'b0;
      stream.dval <= 1'b0;
      stream.x    <= '0;
      stream.y    <= '0;
      frame_count <= '0;
    end else begin
      fval_pin <= ccd_fval;
      lval_pin <= ccd_lval;
      fval_dly <= fval_pin;
      lval_dly <= lval_pin;
      lval_out <= lval_dly;

      // Run flag, stop wins when both keys are down
      if (!stop_n) begin
        running <= 1'b0;
      end else if (!start_n) begin
        running <= 1'b1;
      end

      // Frame acceptance ends at once on stop
      if (!stop_n || fval_fall) begin
        accepted <= 1'b0;
      end else if (frame_start) begin
        accepted <= 1'b1;
      end

      if (frame_start) begin
        frame_count <= frame_count + 1'b1;
      end

      stream.dval <= lval_dly & accepted;   // Gated line valid

      // Column counter
      if (frame_start || lval_fall) begin
        stream.x <= '0;
      end else if (stream.dval) begin
        stream.x <= stream.x + coord_t'(1);
      end

      // Row counter
      if (frame_start) begin
        stream.y <= '0;
      end else if (lval_fall && accepted) begin
        stream.y <= stream.y + coord_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/bayer_demosaic.sv ====
/*
  Bayer demosaic
  Rebuilds one RGB pixel from each 2x2 GRBG block. The line above
  sits in a buffer indexed by column, the current line is held
  one sample back. Output one cycle after the block's last sample
*/
`default_nettype none

module bayer_demosaic (
  input  logic           ccd_pixel_clk,
  input  logic           hps_fpga_reset_n,
  ccd_stream_if.sink     stream,
  output pix_pkg::comp_t red,
  output pix_pkg::comp_t green,
  output pix_pkg::comp_t blue,
  output logic           rgb_valid
);
  import cam_pkg::*;
  import pix_pkg::*;

  // Previous line, one sample per column
  raw_pixel_t line_buf [line_width_max];

  logic [line_addr_width-1:0] addr;
  logic                       wr_en;
  logic                       block_end;    // Bottom-right of a block
  raw_pixel_t                 above;        // Line buffer at x
  raw_pixel_t                 prev_above;   // Line buffer at x-1 (G1)
  raw_pixel_t                 prev_cur;     // Current line at x-1 (B)
  logic [raw_width:0]         green_sum;    // One bit of headroom

  assign addr = stream.x[line_addr_width-1:0];
  assign wr_en = stream.dval && (stream.x < coord_t'(line_width_max));

  // Odd column on odd row closes a block
  assign block_end = wr_en & stream.x[0] & stream.y[0];

  // Read before this sample overwrites it
  assign above = line_buf[addr];

  // G1 from line above, G2 is the incoming sample
  assign green_sum = {1'b0, prev_above} + {1'b0, stream.data};

  //======================================================================
  // Line storage
  //======================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (wr_en) begin
      line_buf[addr] <= stream.data;
      prev_above     <= above;
      prev_cur       <= stream.data;
    end
  end

  //======================================================================
  // Block output
  //======================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (block_end) begin
      red   <= above;                       // R above at x
      green <= green_sum[raw_width:1];      // Mean of both greens
      blue  <= prev_cur;                    // B current at x-1
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= block_end;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rgb_packer.sv ====
/*
  RGB packer
  Keeps the top 5 bits of each component, clears channels whose
  switch is off and registers the 16-bit word with its strobe
*/
`default_nettype none

module rgb_packer (
  input  logic                 ccd_pixel_clk,
  input  logic                 hps_fpga_reset_n,
  input  pix_pkg::comp_t       red,
  input  pix_pkg::comp_t       green,
  input  pix_pkg::comp_t       blue,
  input  logic                 rgb_valid,
  input  logic [2:0]           channel_enable,  // 2 red, 1 green, 0 blue
  output pix_pkg::pixel_word_u pixel_word,
  output logic                 pixel_valid
);
  import pix_pkg::*;

  pixel_word_u word_next;

  // Truncate and mask
  always_comb begin
    word_next.fields.pad   = 1'b0;
    word_next.fields.red   = channel_enable[2] ? red[comp_width-1 -: comp5_width] : '0;
    word_next.fields.green = channel_enable[1] ? green[comp_width-1 -: comp5_width] : '0;
    word_next.fields.blue  = channel_enable[0] ? blue[comp_width-1 -: comp5_width] : '0;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    pixel_word <= word_next;      // Payload
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      pixel_valid <= 1'b0;
    end else begin
      pixel_valid <= rgb_valid;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/frame_count_display.sv ====
/*
  Frame count display
  Shows the low 24 bits of the frame counter as six hex digits
  on active-low seven-segment outputs, hex0 least significant
*/
`default_nettype none

module frame_count_display (
  input  logic                  ccd_pixel_clk,
  input  logic                  hps_fpga_reset_n,
  input  cam_pkg::frame_count_t frame_count,
  output pix_pkg::seg_t         hex0,
  output pix_pkg::seg_t         hex1,
  output pix_pkg::seg_t         hex2,
  output pix_pkg::seg_t         hex3,
  output pix_pkg::seg_t         hex4,
  output pix_pkg::seg_t         hex5
);
  import pix_pkg::*;

  seg_t seg_q [hex_digits];

  // Nibble to segments, gfedcba
  function automatic seg_t seg_lut(input logic [3:0] nibble);
    case (nibble)
      4'h0: seg_lut = 7'b1000000;
      4'h1: seg_lut = 7'b1111001;
      4'h2: seg_lut = 7'b0100100;
      4'h3: seg_lut = 7'b0110000;
      4'h4: seg_lut = 7'b0011001;
      4'h5: seg_lut = 7'b0010010;
      4'h6: seg_lut = 7'b0000010;
      4'h7: seg_lut = 7'b1111000;
      4'h8: seg_lut = 7'b0000000;
      4'h9: seg_lut = 7'b0010000;
      4'ha: seg_lut = 7'b0001000;
      4'hb: seg_lut = 7'b0000011;   // Lower case b
      4'hc: seg_lut = 7'b1000110;
      4'hd: seg_lut = 7'b0100001;   // Lower case d
      4'he: seg_lut = 7'b0000110;
      default: seg_lut = 7'b0001110;  // F
    endcase
  endfunction

  always_ff @(posedge ccd_pixel_clk) begin
    for (int i = 0; i < hex_digits; i++) begin
      if (!hps_fpga_reset_n) begin
        seg_q[i] <= seg_lut(4'h0);    // Count is zero after reset
      end else begin
        seg_q[i] <= seg_lut(frame_count[4*i +: 4]);
      end
    end
  end

  assign hex0 = seg_q[0];
  assign hex1 = seg_q[1];
  assign hex2 = seg_q[2];
  assign hex3 = seg_q[3];
  assign hex4 = seg_q[4];
  assign hex5 = seg_q[5];

endmodule

`default_nettype wire

// ==== verilog/camera_capture_top.sv ====
/*
  Camera capture top level
  Pin capture, Bayer demosaic and RGB packing on the pixel clock,
  plus the frame counter on six seven-segment digits
*/
`default_nettype none

module camera_capture_top (
  input  logic                            ccd_pixel_clk,
  input  logic                            hps_fpga_reset_n,
  input  logic [cam_pkg::raw_width-1:0]   ccd_data,
  input  logic                            ccd_fval,
  input  logic                            ccd_lval,
  input  logic                            start_n,         // Key, low starts
  input  logic                            stop_n,          // Key, low stops
  input  logic [2:0]                      channel_enable,  // Switches R G B
  output logic [pix_pkg::word_width-1:0]  pixel_word,
  output logic                            pixel_valid,
  output logic [pix_pkg::seg_width-1:0]   hex0,
  output logic [pix_pkg::seg_width-1:0]   hex1,
  output logic [pix_pkg::seg_width-1:0]   hex2,
  output logic [pix_pkg::seg_width-1:0]   hex3,
  output logic [pix_pkg::seg_width-1:0]   hex4,
  output logic [pix_pkg::seg_width-1:0]   hex5
);
  import cam_pkg::*;
  import pix_pkg::*;

  frame_count_t frame_count;
  comp_t        rgb_red, rgb_green, rgb_blue;
  logic         rgb_valid;
  pixel_word_u  packed_word;

  ccd_stream_if stream_bus ();

  // Sensor pins to tagged stream
  ccd_capture u_capture (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ccd_data         (ccd_data),
    .ccd_fval         (ccd_fval),
    .ccd_lval         (ccd_lval),
    .start_n          (start_n),
    .stop_n           (stop_n),
    .stream           (stream_bus.source),
    .frame_count      (frame_count)
  );

  bayer_demosaic u_demosaic (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .stream           (stream_bus.sink),
    .red              (rgb_red),
    .green            (rgb_green),
    .blue             (rgb_blue),
    .rgb_valid        (rgb_valid)
  );

  rgb_packer u_packer (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .red              (rgb_red),
    .green            (rgb_green),
    .blue             (rgb_blue),
    .rgb_valid        (rgb_valid),
    .channel_enable   (channel_enable),
    .pixel_word       (packed_word),
    .pixel_valid      (pixel_valid)
  );

  assign pixel_word = packed_word.raw;   // Bus view of the word

  frame_count_display u_display (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .frame_count      (frame_count),
    .hex0             (hex0),
    .hex1             (hex1),
    .hex2             (hex2),
    .hex3             (hex3),
    .hex4             (hex4),
    .hex5             (hex5)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
/*
  Testbench clock and reset
  10 ns pixel clock, reset held low for two rising edges
*/
`default_nettype none

module tb_clock_gen (
  output logic ccd_pixel_clk,
  output logic hps_fpga_reset_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 5;   // ns
  localparam int reset_cycles = 2;

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #(half_period) ccd_pixel_clk = ~ccd_pixel_clk;
  end

  // Release on a falling edge like every other input
  initial begin
    hps_fpga_reset_n = 1'b0;
    repeat (reset_cycles) @(posedge ccd_pixel_clk);
    @(negedge ccd_pixel_clk);
    hps_fpga_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/camera_capture_props.sv ====
/*
  Camera capture properties
  Output strobe after reset, pad bit of the word and the
  spacing of consecutive output words
*/
`default_nettype none

module camera_capture_props (
  input logic                           ccd_pixel_clk,
  input logic                           hps_fpga_reset_n,
  input logic [pix_pkg::word_width-1:0] pixel_word,
  input logic                           pixel_valid
);
  timeunit 1ns;
  timeprecision 100ps;

  // Whole pipeline leaves reset empty, not just the last stage
  valid_low_after_reset: assert property (
    @(posedge ccd_pixel_clk)
    $rose(hps_fpga_reset_n) |-> !pixel_valid ##1 !pixel_valid ##1 !pixel_valid
  ) else $error("pixel_valid high in the first cycles after reset");

  // Top bit of the word is the pad
  pad_bit_zero: assert property (
    @(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    pixel_valid |-> !pixel_word[pix_pkg::word_width-1]
  ) else $error("pad bit set on a valid pixel word");

  // Blocks close on odd columns only, so strobes never touch
  valid_spaced: assert property (
    @(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    pixel_valid |=> !pixel_valid
  ) else $error("pixel_valid high in two consecutive cycles");

endmodule

bind camera_capture_top camera_capture_props u_props (
  .ccd_pixel_clk    (ccd_pixel_clk),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .pixel_word       (pixel_word),
  .pixel_valid      (pixel_valid)
);

`default_nettype wire

// ==== testbench/tb_camera_capture.sv ====
/*
  Camera capture testbench
  Sensor model sending 8x4 GRBG frames, a reference model of the
  demosaic and packer rules, and directed tests for run control,
  channel masking and the frame count display
*/
`default_nettype none

module tb_camera_capture;
  timeunit 1ns;
  timeprecision 100ps;
  import cam_pkg::*;
  import pix_pkg::*;

  localparam int frame_cols = 8;
  localparam int frame_rows = 4;
  localparam int wait_limit = 200;          // Cycles allowed per wait
  localparam int pipe_latency = 4;          // Sample edge to pixel_valid
  localparam seg_t seg_zero = 7'b1000000;   // Active-low digit 0

  logic                  ccd_pixel_clk;
  logic                  hps_fpga_reset_n;
  raw_pixel_t            ccd_data;
  logic                  ccd_fval, ccd_lval;
  logic                  start_n, stop_n;
  logic [2:0]            channel_enable;
  logic [word_width-1:0] pixel_word;
  logic                  pixel_valid;
  seg_t                  hex0, hex1, hex2, hex3, hex4, hex5;

  int           seed = 32'hb70;
  int           errors = 0;
  int           timeouts = 0;
  int           cycle = 0;                  // Rising edges so far
  frame_count_t frames_expected = '0;
  pixel_word_u  word_q [$];                 // Expected words in order
  int           due_q [$];                  // Cycle each word is due
  raw_pixel_t   pix [frame_rows][frame_cols];

  tb_clock_gen u_clk (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n)
  );

  camera_capture_top u_dut (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .ccd_data         (ccd_data),
    .ccd_fval         (ccd_fval),
    .ccd_lval         (ccd_lval),
    .start_n          (start_n),
    .stop_n           (stop_n),
    .channel_enable   (channel_enable),
    .pixel_word       (pixel_word),
    .pixel_valid      (pixel_valid),
    .hex0             (hex0),
    .hex1             (hex1),
    .hex2             (hex2),
    .hex3             (hex3),
    .hex4             (hex4),
    .hex5             (hex5)
  );

  always @(posedge ccd_pixel_clk) cycle <= cycle + 1;

  //======================================================================
  // Reference model
  //======================================================================
  // One 2x2 GRBG block to a masked 5-5-5 word
  function automatic pixel_word_u model_word(input raw_pixel_t g1, input raw_pixel_t r,
                                             input raw_pixel_t b, input raw_pixel_t g2,
                                             input logic [2:0] en);
    pixel_word_u        w;
    logic [raw_width:0] gsum;
    gsum = {1'b0, g1} + {1'b0, g2};
    w.raw = '0;
    w.fields.red   = en[2] ? r[11:7] : 5'd0;
    w.fields.green = en[1] ? gsum[12:8] : 5'd0;   // Top bits of the mean
    w.fields.blue  = en[0] ? b[11:7] : 5'd0;
    return w;
  endfunction

  // Active-low pattern back to a hex digit
  function automatic logic [3:0] seg_to_nibble(input seg_t seg);
    case (seg)
      7'b1000000: return 4'h0;
      7'b1111001: return 4'h1;
      7'b0100100: return 4'h2;
      7'b0110000: return 4'h3;
      7'b0011001: return 4'h4;
      7'b0010010: return 4'h5;
      7'b0000010: return 4'h6;
      7'b1111000: return 4'h7;
      7'b0000000: return 4'h8;
      7'b0010000: return 4'h9;
      7'b0001000: return 4'ha;
      7'b0000011: return 4'hb;
      7'b1000110: return 4'hc;
      7'b0100001: return 4'hd;
      7'b0000110: return 4'he;
      7'b0001110: return 4'hf;
      default:    return 4'bxxxx;   // Not a digit
    endcase
  endfunction

  //======================================================================
  // Compare tasks
  //======================================================================
  task automatic check_word(input pixel_word_u got, input pixel_word_u exp);
    if (got.raw !== exp.raw) begin
      errors++;
      $display("Mismatch at %0t: pixel word %h, expected %h", $time, got.raw, exp.raw);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("Mismatch at %0t: word in cycle %0d, expected cycle %0d", $time, got, exp);
    end
  endtask

  task automatic check_segments(input seg_t got, input seg_t exp, input int digit);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: hex%0d is %b, expected %b", $time, digit, got, exp);
    end
  endtask

  task automatic check_count(input frame_count_t exp);
    logic [23:0] shown;
    shown = {seg_to_nibble(hex5), seg_to_nibble(hex4), seg_to_nibble(hex3),
             seg_to_nibble(hex2), seg_to_nibble(hex1), seg_to_nibble(hex0)};
    if (shown !== exp[23:0]) begin
      errors++;
      $display("Mismatch at %0t: display shows %h, expected %h", $time, shown, exp[23:0]);
    end
  endtask

  // Every strobe is matched with the oldest queued word
  always @(negedge ccd_pixel_clk) begin : monitor
    pixel_word_u got;
    if (hps_fpga_reset_n && pixel_valid) begin
      got.raw = pixel_word;
      if (word_q.size() == 0) begin
        errors++;
        $display("Error at %0t: pixel_valid high with no word expected", $time);
      end else begin
        check_word(got, word_q.pop_front());
        check_latency(cycle, due_q.pop_front());
      end
    end
  end

  //======================================================================
  // Stimulus
  //======================================================================
  task automatic press_key(input bit stop);
    @(negedge ccd_pixel_clk);
    if (stop) begin
      stop_n = 1'b0;
    end else begin
      start_n = 1'b0;
    end
    @(negedge ccd_pixel_clk);
    stop_n  = 1'b1;
    start_n = 1'b1;
  endtask

  // Words queued only for a frame that gets captured
  task automatic send_frame(input bit accepted);
    @(negedge ccd_pixel_clk);
    ccd_fval = 1'b1;
    repeat (3) @(negedge ccd_pixel_clk);        // Lead before first line
    for (int row = 0; row < frame_rows; row++) begin
      for (int col = 0; col < frame_cols; col++) begin
        ccd_lval = 1'b1;
        ccd_data = raw_pixel_t'($random(seed));
        pix[row][col] = ccd_data;
        if (accepted && row[0] && col[0]) begin   // Bottom-right of a block
          word_q.push_back(model_word(pix[row-1][col-1], pix[row-1][col],
                                      pix[row][col-1], pix[row][col], channel_enable));
          due_q.push_back(cycle + 1 + pipe_latency);
        end
        @(negedge ccd_pixel_clk);
      end
      ccd_lval = 1'b0;
      repeat (4) @(negedge ccd_pixel_clk);      // Line gap
    end
    ccd_fval = 1'b0;
    repeat (6) @(negedge ccd_pixel_clk);        // Pipeline flush
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (word_q.size() != 0 && waited < wait_limit) begin
      @(negedge ccd_pixel_clk);
      waited++;
    end
    if (word_q.size() != 0) begin
      timeouts++;
      $display("Timeout at %0t: %0d expected words never appeared", $time, word_q.size());
      word_q.delete();
      due_q.delete();
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (!hps_fpga_reset_n && waited < wait_limit) begin
      @(negedge ccd_pixel_clk);
      waited++;
    end
    if (!hps_fpga_reset_n) begin
      timeouts++;
      $display("Timeout at %0t: reset was never released", $time);
    end
  endtask

  //======================================================================
  // Directed tests
  //======================================================================
  task automatic idle_after_reset();
    check_segments(hex0, seg_zero, 0);
    check_segments(hex1, seg_zero, 1);
    check_segments(hex2, seg_zero, 2);
    check_segments(hex3, seg_zero, 3);
    check_segments(hex4, seg_zero, 4);
    check_segments(hex5, seg_zero, 5);
    send_frame(1'b0);                           // Not running yet
    check_count(frames_expected);
  endtask

  task automatic full_frame_words();
    channel_enable = 3'b111;
    press_key(1'b0);
    send_frame(1'b1);
    frames_expected++;
    wait_drain();
    check_count(frames_expected);
  endtask

  task automatic channel_masking();
    for (int i = 0; i < 3; i++) begin
      channel_enable = 3'(1 << i);              // Blue, green, red alone
      send_frame(1'b1);
      frames_expected++;
      wait_drain();
    end
    channel_enable = 3'b111;
    check_count(frames_expected);
  endtask

  task automatic frame_counting();
    repeat (2) begin
      send_frame(1'b1);
      frames_expected++;
      wait_drain();
    end
    check_count(frames_expected);
    press_key(1'b1);
    send_frame(1'b0);                           // Ignored while stopped
    check_count(frames_expected);
  endtask

  task automatic midframe_start();
    fork
      send_frame(1'b0);
      begin
        repeat (8) @(negedge ccd_pixel_clk);    // Inside the first line
        press_key(1'b0);
      end
    join
    check_count(frames_expected);
    send_frame(1'b1);
    frames_expected++;
    wait_drain();
    check_count(frames_expected);
  endtask

  initial begin
    ccd_data       = '0;
    ccd_fval       = 1'b0;
    ccd_lval       = 1'b0;
    start_n        = 1'b1;
    stop_n         = 1'b1;
    channel_enable = 3'b111;
    wait_reset_release();
    repeat (2) @(negedge ccd_pixel_clk);
    idle_after_reset();
    full_frame_words();
    channel_masking();
    frame_counting();
    midframe_start();
    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/cam_pkg.sv
verilog/pix_pkg.sv
verilog/ccd_stream_if.sv
verilog/ccd_capture.sv
verilog/bayer_demosaic.sv
verilog/rgb_packer.sv
verilog/frame_count_display.sv
verilog/camera_capture_top.sv
testbench/tb_clock_gen.sv
testbench/camera_capture_props.sv
testbench/tb_camera_capture.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_camera_capture
FILELIST  := files.f

BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
